// File: common/riscv_div_pkg.sv
`default_nettype none

package riscv_div_pkg;

  ////////////////////
  // instruction fields
  ////////////////////

  // R-type OP major opcode, instr[6:2]
  localparam logic [4:0] opcode_op     = 5'b01100;

  // funct7 of the M extension
  localparam logic [6:0] funct7_muldiv = 7'b0000001;

  // funct3 of the divide group, all have bit 2 set
  localparam logic [2:0] funct3_div    = 3'b100;
  localparam logic [2:0] funct3_divu   = 3'b101;
  localparam logic [2:0] funct3_rem    = 3'b110;
  localparam logic [2:0] funct3_remu   = 3'b111;

  ////////////////////
  // types
  ////////////////////

  // decoded divide operation, held for the result stage
  typedef enum logic [1:0] {
    OP_DIV  = 2'b00,
    OP_DIVU = 2'b01,
    OP_REM  = 2'b10,
    OP_REMU = 2'b11
  } div_op_e;

  // controller FSM
  typedef enum logic [1:0] {
    ST_CHK = 2'b00, // idle, exception check
    ST_DIV = 2'b01, // iterating
    ST_RES = 2'b10  // result handoff
  } div_state_e;

endpackage

`default_nettype wire

// File: common/div_iter_if.sv
`default_nettype none

// controller -> iteration unit -> result stage
interface div_iter_if #(
  parameter int XLEN = 32
);

  logic            load;         // one cycle, starts a division
  logic [XLEN-1:0] dividend_mag; // |dividend|
  logic [XLEN-1:0] divisor_mag;  // |divisor|
  logic [XLEN-1:0] quotient;     // magnitude
  logic [XLEN-1:0] remainder;    // magnitude

  modport ctrl (
    output load, dividend_mag, divisor_mag
  );

  modport iter (
    input  load, dividend_mag, divisor_mag,
    output quotient, remainder
  );

  modport result (
    input quotient, remainder
  );

endinterface

`default_nettype wire

// File: common/div_fin_if.sv
`default_nettype none

// early results and finish info, controller -> result stage
interface div_fin_if #(
  parameter int XLEN = 32
);

  logic                   early_valid; // exception result this cycle
  logic [XLEN-1:0]        early_value;
  logic                   finish;      // iteration done, take q or s
  riscv_div_pkg::div_op_e op;          // held op of the running division
  logic                   neg_q;       // negate quotient
  logic                   neg_s;       // negate remainder

  modport ctrl (
    output early_valid, early_value, finish, op, neg_q, neg_s
  );

  modport result (
    input early_valid, early_value, finish, op, neg_q, neg_s
  );

endinterface

`default_nettype wire

// File: divider/div_ctrl.sv
`default_nettype none

module div_ctrl #(
  parameter int XLEN = 32
)
(
  input  logic            clk,
  input  logic            rstn,

  input  logic            id_bubble,
  input  logic [31:0]     id_instr,
  input  logic [XLEN-1:0] op_a,      // dividend
  input  logic [XLEN-1:0] op_b,      // divisor

  output logic            div_stall,

  div_iter_if.ctrl        iter_bus,
  div_fin_if.ctrl         fin_bus
);

  localparam int CW = (XLEN > 1) ? $clog2(XLEN) : 1;

  // most negative signed value
  localparam logic [XLEN-1:0] MIN_NEG = {1'b1, {XLEN-1{1'b0}}};

  ////////////////////
  // decode
  ////////////////////

  logic                   is_divop;  // one of DIV/DIVU/REM/REMU
  riscv_div_pkg::div_op_e op_dec;
  logic                   is_signed;
  logic                   is_quot;   // DIV or DIVU
  logic                   div_zero;
  logic                   sgn_ovf;
  logic                   accept;
  logic                   exc;

  riscv_div_pkg::div_state_e state;
  logic [CW-1:0]             cnt;

  always_comb
  begin
    op_dec = riscv_div_pkg::OP_DIV;
    case (id_instr[14:12])
      riscv_div_pkg::funct3_div:  op_dec = riscv_div_pkg::OP_DIV;
      riscv_div_pkg::funct3_divu: op_dec = riscv_div_pkg::OP_DIVU;
      riscv_div_pkg::funct3_rem:  op_dec = riscv_div_pkg::OP_REM;
      riscv_div_pkg::funct3_remu: op_dec = riscv_div_pkg::OP_REMU;
      default:                    op_dec = riscv_div_pkg::OP_DIV;
    endcase
  end

  // MUL group shares funct7/opcode, funct3[2] splits it off
  assign is_divop = (id_instr[31:25] == riscv_div_pkg::funct7_muldiv) &&
                    (id_instr[6:2]   == riscv_div_pkg::opcode_op)     &&
                    id_instr[14];

  assign is_signed = (op_dec == riscv_div_pkg::OP_DIV) || (op_dec == riscv_div_pkg::OP_REM);
  assign is_quot   = (op_dec == riscv_div_pkg::OP_DIV) || (op_dec == riscv_div_pkg::OP_DIVU);

  ////////////////////
  // exception check
  ////////////////////

  assign div_zero = ~|op_b;
  assign sgn_ovf  = is_signed && (op_a == MIN_NEG) && (&op_b); // -2^(XLEN-1) / -1

  assign accept = (state == riscv_div_pkg::ST_CHK) && !id_bubble && is_divop;
  assign exc    = div_zero || sgn_ovf;

  assign fin_bus.early_valid = accept && exc;
  assign iter_bus.load       = accept && !exc; // normal path

  always_comb
  begin
    if (div_zero)
      fin_bus.early_value = is_quot ? {XLEN{1'b1}} : op_a; // q = -1 / 2^XLEN-1, s = dividend
    else
      fin_bus.early_value = is_quot ? MIN_NEG : '0;        // overflow: q = dividend, s = 0
  end

  // operand magnitudes, unsigned ops pass through
  assign iter_bus.dividend_mag = (is_signed && op_a[XLEN-1]) ? -op_a : op_a;
  assign iter_bus.divisor_mag  = (is_signed && op_b[XLEN-1]) ? -op_b : op_b;

  ////////////////////
  // fsm and counter
  ////////////////////

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      state     <= riscv_div_pkg::ST_CHK;
      cnt       <= '0;
      div_stall <= 1'b0;
    end
    else
    begin
      case (state)
        riscv_div_pkg::ST_CHK:
        begin
          if (iter_bus.load)
          begin
            state     <= riscv_div_pkg::ST_DIV;
            cnt       <= CW'(XLEN - 1); // XLEN steps
            div_stall <= 1'b1;
          end
        end

        riscv_div_pkg::ST_DIV:
        begin
          cnt <= cnt - 1'b1;
          if (cnt == '0)
            state <= riscv_div_pkg::ST_RES; // last step taken
        end

        riscv_div_pkg::ST_RES:
        begin
          state     <= riscv_div_pkg::ST_CHK;
          div_stall <= 1'b0; // drops together with the result
        end

        default:
        begin
          state     <= riscv_div_pkg::ST_CHK;
          div_stall <= 1'b0;
        end
      endcase
    end
  end

  assign fin_bus.finish = (state == riscv_div_pkg::ST_RES);

  // op and sign flags, held from load until finish
  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      fin_bus.op    <= riscv_div_pkg::OP_DIV;
      fin_bus.neg_q <= 1'b0;
      fin_bus.neg_s <= 1'b0;
    end
    else if (iter_bus.load)
    begin
      fin_bus.op    <= op_dec;
      fin_bus.neg_q <= is_signed && (op_a[XLEN-1] ^ op_b[XLEN-1]);
      fin_bus.neg_s <= is_signed && op_a[XLEN-1]; // remainder follows dividend
    end
  end

endmodule

`default_nettype wire

// File: divider/div_iter.sv
`default_nettype none

module div_iter #(
  parameter int XLEN = 32
)
(
  input  logic      clk,
  input  logic      rstn,

  div_iter_if.iter  iter_bus
);

  // partial remainder / quotient pair, shifted as one word
  typedef union packed {
    logic [2*XLEN-1:0] word;
    struct packed {
      logic [XLEN-1:0] p; // partial remainder
      logic [XLEN-1:0] a; // dividend in, quotient out
    } half;
  } div_pa_u;

  div_pa_u         pa;
  div_pa_u         pa_sh;     // pa << 1
  logic [XLEN-1:0] b;         // divisor magnitude
  logic [XLEN:0]   p_minus_b; // msb set -> negative, restore

  assign pa_sh.word = pa.word << 1;

  // keep the bit shifted out of p, else large unsigned divisors break
  assign p_minus_b = {pa.half.p[XLEN-1], pa_sh.half.p} - {1'b0, b};

  ////////////////////
  // restoring step
  ////////////////////

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      pa.word <= '0;
      b       <= '0;
    end
    else if (iter_bus.load)
    begin
      pa.half.p <= '0;
      pa.half.a <= iter_bus.dividend_mag;
      b         <= iter_bus.divisor_mag;
    end
    else if (p_minus_b[XLEN])
    begin
      pa <= pa_sh; // restore, q bit 0 already shifted in
    end
    else
    begin
      pa.half.p <= p_minus_b[XLEN-1:0];                 // keep difference
      pa.half.a <= {pa_sh.half.a[XLEN-1:1], 1'b1};      // q bit 1
    end
  end

  assign iter_bus.quotient  = pa.half.a;
  assign iter_bus.remainder = pa.half.p;

endmodule

`default_nettype wire

// File: divider/div_result.sv
`default_nettype none

module div_result #(
  parameter int XLEN = 32
)
(
  input  logic            clk,
  input  logic            rstn,

  output logic            div_bubble,
  output logic [XLEN-1:0] div_r,

  div_iter_if.result      iter_bus,
  div_fin_if.result       fin_bus
);

  logic [XLEN-1:0] res_q;   // signed-fixed quotient
  logic [XLEN-1:0] res_s;   // signed-fixed remainder
  logic [XLEN-1:0] res_sel;

  ////////////////////
  // sign fixup
  ////////////////////

  assign res_q = fin_bus.neg_q ? -iter_bus.quotient  : iter_bus.quotient;
  assign res_s = fin_bus.neg_s ? -iter_bus.remainder : iter_bus.remainder;

  always_comb
  begin
    case (fin_bus.op)
      riscv_div_pkg::OP_DIV,
      riscv_div_pkg::OP_DIVU: res_sel = res_q;
      default:                res_sel = res_s; // REM, REMU
    endcase
  end

  // result word
  always_ff @(posedge clk)
  begin
    if (fin_bus.early_valid)
      div_r <= fin_bus.early_value;
    else if (fin_bus.finish)
      div_r <= res_sel;
  end

  // valid for one cycle after either pulse
  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
      div_bubble <= 1'b1;
    else
      div_bubble <= ~(fin_bus.early_valid | fin_bus.finish);
  end

endmodule

`default_nettype wire

// File: hdl/riscv_div_top.sv
`default_nettype none

module riscv_div_top #(
  parameter int XLEN = 32
)
(
  input  logic            clk,
  input  logic            rstn,

  // from decode
  input  logic            id_bubble,
  input  logic [31:0]     id_instr,
  input  logic [XLEN-1:0] op_a,
  input  logic [XLEN-1:0] op_b,

  output logic            div_stall,  // hold upstream while high

  // to writeback
  output logic            div_bubble,
  output logic [XLEN-1:0] div_r
);

  div_iter_if #(.XLEN(XLEN)) iter_bus ();
  div_fin_if  #(.XLEN(XLEN)) fin_bus ();

  // decode, exceptions, fsm
  div_ctrl #(.XLEN(XLEN)) u_ctrl (
    .clk       (clk),
    .rstn      (rstn),
    .id_bubble (id_bubble),
    .id_instr  (id_instr),
    .op_a      (op_a),
    .op_b      (op_b),
    .div_stall (div_stall),
    .iter_bus  (iter_bus.ctrl),
    .fin_bus   (fin_bus.ctrl)
  );

  // bit-serial core
  div_iter #(.XLEN(XLEN)) u_iter (
    .clk      (clk),
    .rstn     (rstn),
    .iter_bus (iter_bus.iter)
  );

  // sign fixup and output regs
  div_result #(.XLEN(XLEN)) u_result (
    .clk        (clk),
    .rstn       (rstn),
    .div_bubble (div_bubble),
    .div_r      (div_r),
    .iter_bus   (iter_bus.result),
    .fin_bus    (fin_bus.result)
  );

endmodule

`default_nettype wire

// File: bench/riscv_div_checker.sv
`default_nettype none

module riscv_div_checker (
  input logic                      clk,
  input logic                      rstn,
  input logic                      div_bubble,
  input logic                      div_stall,
  input riscv_div_pkg::div_state_e state    // controller FSM
);

  timeunit 1ns;
  timeprecision 1ps;

  ////////////////////
  // output protocol
  ////////////////////

  // idle outputs on the first edge out of reset
  a_reset_idle: assert property (@(posedge clk)
    $rose(rstn) |-> (div_bubble && !div_stall))
    else $error("div_bubble or div_stall not idle after reset");

  // result valid one cycle only
  a_single_result: assert property (@(posedge clk) disable iff (!rstn)
    !div_bubble |=> div_bubble)
    else $error("div_bubble low for two cycles in a row");

  // stall drops with the result
  a_stall_release: assert property (@(posedge clk) disable iff (!rstn)
    $fell(div_stall) |-> !div_bubble)
    else $error("div_stall fell without a result on div_bubble");

  a_stall_busy: assert property (@(posedge clk) disable iff (!rstn)
    div_stall |-> (state != riscv_div_pkg::ST_CHK))
    else $error("div_stall high while the FSM is idle");

endmodule

bind riscv_div_top riscv_div_checker u_checker (
  .clk        (clk),
  .rstn       (rstn),
  .div_bubble (div_bubble),
  .div_stall  (div_stall),
  .state      (u_ctrl.state)
);

`default_nettype wire

// File: bench/tb_riscv_div.sv
`default_nettype none

module tb_riscv_div;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int XLEN    = 32;
  localparam int N_RAND  = 40;        // ops per random group
  localparam int TIMEOUT = XLEN + 10; // cycles allowed for div_bubble
  localparam int IDLE    = 40;        // quiet cycles for ignored input
  localparam logic [XLEN-1:0] MIN_NEG = {1'b1, {XLEN-1{1'b0}}};

  logic            clk = 1'b0;
  logic            rstn;
  logic            id_bubble;
  logic [31:0]     id_instr;
  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  logic            div_stall;
  logic            div_bubble;
  logic [XLEN-1:0] div_r;

  logic [31:0] rng    = 32'd3; // xorshift state
  int          errors = 0;
  int          tests  = 0;

  riscv_div_top #(.XLEN(XLEN)) dut (
    .clk(clk), .rstn(rstn), .id_bubble(id_bubble), .id_instr(id_instr),
    .op_a(op_a), .op_b(op_b), .div_stall(div_stall), .div_bubble(div_bubble), .div_r(div_r)
  );

  always #5 clk = ~clk; // 10 ns

  ////////////////////
  // random numbers
  ////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    return s ^ (s << 5);
  endfunction

  function automatic logic [31:0] rand32();
    rng = xorshift32(rng);
    return rng;
  endfunction

  function automatic logic [XLEN-1:0] rand_word();
    logic [XLEN-1:0] w;
    w = '0;
    for (int i = 0; i < XLEN; i += 32)
      w = (w << 32) | XLEN'(rand32());
    return w;
  endfunction

  // full range, shifted down, small, small negative
  function automatic logic [XLEN-1:0] rand_operand();
    logic [31:0]     r;
    logic [XLEN-1:0] w;
    r = rand32();
    w = rand_word();
    case (r[1:0])
      2'd1:    w = w >> r[6:2];
      2'd2:    w = w & 'hff;   // may hit zero now and then
      2'd3:    w = -(w & 'hf);
      default: ;
    endcase
    return w;
  endfunction

  // R-type word, register fields random
  function automatic logic [31:0] make_instr(input logic [6:0] f7, input logic [2:0] f3,
                                             input logic [4:0] opc);
    logic [31:0] r;
    r = rand32();
    return {f7, r[14:5], f3, r[4:0], opc, 2'b11};
  endfunction

  function automatic logic [31:0] div_instr(input riscv_div_pkg::div_op_e op);
    logic [2:0] f3;
    case (op)
      riscv_div_pkg::OP_DIV:  f3 = riscv_div_pkg::funct3_div;
      riscv_div_pkg::OP_DIVU: f3 = riscv_div_pkg::funct3_divu;
      riscv_div_pkg::OP_REM:  f3 = riscv_div_pkg::funct3_rem;
      default:                f3 = riscv_div_pkg::funct3_remu;
    endcase
    return make_instr(riscv_div_pkg::funct7_muldiv, f3, riscv_div_pkg::opcode_op);
  endfunction

  ////////////////////
  // reference model
  ////////////////////

  function automatic bit early_path(input riscv_div_pkg::div_op_e op,
                                    input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
    bit sgn;
    sgn = (op == riscv_div_pkg::OP_DIV) || (op == riscv_div_pkg::OP_REM);
    return (b == '0) || (sgn && (a == MIN_NEG) && (b == '1));
  endfunction

  function automatic logic [XLEN-1:0] model_div(input riscv_div_pkg::div_op_e op,
                                                input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b);
    logic [XLEN-1:0] r;
    bit              quot;
    quot = (op == riscv_div_pkg::OP_DIV) || (op == riscv_div_pkg::OP_DIVU);
    if (b == '0)
      r = quot ? {XLEN{1'b1}} : a; // x/0
    else if (early_path(op, a, b))
      r = quot ? MIN_NEG : '0;     // signed overflow
    else
      case (op)
        riscv_div_pkg::OP_DIV:  r = $signed(a) / $signed(b); // truncates toward zero
        riscv_div_pkg::OP_REM:  r = $signed(a) % $signed(b); // sign of dividend
        riscv_div_pkg::OP_DIVU: r = a / b;
        default:                r = a % b;
      endcase
    return r;
  endfunction

  ////////////////////
  // compare tasks
  ////////////////////

  task automatic check_word(input string name, input logic [XLEN-1:0] exp, act);
    if (act !== exp)
    begin
      $display("Fail %s: expected %h, got %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, act);
    if (act !== exp)
    begin
      $display("Fail %s: expected %h, got %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_latency(input string name, input int exp, act);
    if (act != exp)
    begin
      $display("Fail %s: expected %h, got %h", name, exp, act);
      errors++;
    end
  endtask

  ////////////////////
  // tests
  ////////////////////

  task automatic check_reset();
    int err0;
    err0 = errors;
    repeat (5)
    begin
      @(negedge clk);
      check_flag("div_bubble", 1'b1, div_bubble);
      check_flag("div_stall", 1'b0, div_stall);
    end
    @(posedge clk);
    rstn <= 1'b1;
    repeat (3)
    begin
      @(negedge clk);
      check_flag("div_bubble", 1'b1, div_bubble); // idle after release
      check_flag("div_stall", 1'b0, div_stall);
    end
    tests++;
    $display("test %0d reset: %s", tests, (errors == err0) ? "ok" : "FAIL");
  endtask

  task automatic run_op(input riscv_div_pkg::div_op_e op, input logic [XLEN-1:0] a, b);
    logic [XLEN-1:0]        exp_r;
    logic [31:0]            r;
    riscv_div_pkg::div_op_e noise_op;
    bit                     exc;
    bit                     done;
    int                     cycles;
    int                     err0;
    exp_r  = model_div(op, a, b);
    exc    = early_path(op, a, b);
    err0   = errors;
    cycles = 0;
    done   = 1'b0;
    @(posedge clk);
    id_bubble <= 1'b0;
    id_instr  <= div_instr(op);
    op_a      <= a;
    op_b      <= b;
    @(posedge clk); // accepting edge
    id_bubble <= 1'b1;
    op_a      <= rand_word(); // operands are not held by upstream here
    op_b      <= rand_word();
    while (!done && cycles < TIMEOUT)
    begin
      @(negedge clk);
      cycles++;
      if (!div_bubble)
      begin
        done = 1'b1;
        check_word("div_r", exp_r, div_r);
        check_flag("div_stall", 1'b0, div_stall);
        check_latency("div_bubble latency", exc ? 1 : XLEN + 2, cycles);
      end
      else
      begin
        check_flag("div_stall", !exc, div_stall);
        @(posedge clk);
        if (!exc && cycles < XLEN)
        begin
          // live divide ops while busy, must be ignored
          r         = rand32();
          noise_op  = riscv_div_pkg::div_op_e'(r[1:0]);
          id_bubble <= r[2];
          id_instr  <= div_instr(noise_op);
          op_b      <= r[3] ? '0 : rand_word();
        end
        else
          id_bubble <= 1'b1;
      end
    end
    if (!done)
    begin
      $display("timeout: div_bubble stayed high %0d cycles after %s", cycles, op.name());
      errors++;
    end
    tests++;
    $display("test %0d %s a=%h b=%h r=%h after %0d cycles: %s", tests, op.name(), a, b,
             div_r, cycles, (errors == err0) ? "ok" : "FAIL");
  endtask

  task automatic run_ignored(input string what, input logic bub, input logic [31:0] instr,
                             input logic [XLEN-1:0] b);
    int err0;
    err0 = errors;
    @(posedge clk);
    id_bubble <= bub;
    id_instr  <= instr;
    op_a      <= rand_word();
    op_b      <= b;
    for (int i = 0; i < IDLE; i++)
    begin
      @(negedge clk);
      check_flag("div_bubble", 1'b1, div_bubble);
      check_flag("div_stall", 1'b0, div_stall);
    end
    @(posedge clk);
    id_bubble <= 1'b1;
    tests++;
    $display("test %0d ignored %s: %s", tests, what, (errors == err0) ? "ok" : "FAIL");
  endtask

  initial
  begin
    riscv_div_pkg::div_op_e op;
    logic [31:0]            r;
    logic [XLEN-1:0]        a;
    logic [XLEN-1:0]        b;
    rstn      = 1'b0;
    id_bubble = 1'b1;
    id_instr  = '0;
    op_a      = '0;
    op_b      = '0;
    check_reset();
    for (int i = 0; i < 2 * N_RAND; i++)
    begin
      r  = rand32();
      a  = rand_operand();
      b  = rand_operand();
      if (i < N_RAND)
        op = r[0] ? riscv_div_pkg::OP_REM : riscv_div_pkg::OP_DIV;   // signed group
      else
        op = r[0] ? riscv_div_pkg::OP_REMU : riscv_div_pkg::OP_DIVU; // unsigned group
      run_op(op, a, b);
    end
    for (int k = 0; k < 4; k++)
    begin
      a = rand_word();
      run_op(riscv_div_pkg::div_op_e'(k), a, '0);           // divide by zero
    end
    for (int k = 0; k < 4; k++)
      run_op(riscv_div_pkg::div_op_e'(k), MIN_NEG, '1);     // overflow, or normal if unsigned
    run_ignored("MUL", 1'b0, make_instr(riscv_div_pkg::funct7_muldiv, 3'b000,
                riscv_div_pkg::opcode_op), '0);
    run_ignored("funct7", 1'b0, make_instr(7'b0100000, riscv_div_pkg::funct3_div,
                riscv_div_pkg::opcode_op), '0);
    run_ignored("opcode", 1'b0, make_instr(riscv_div_pkg::funct7_muldiv,
                riscv_div_pkg::funct3_rem, 5'b00100), rand_word());
    run_ignored("DIV in bubble", 1'b1, div_instr(riscv_div_pkg::OP_DIV), rand_word());
    run_ignored("REMU in bubble", 1'b1, div_instr(riscv_div_pkg::OP_REMU), '0);
    $display("%0d tests run, %0d errors", tests, errors);
    if (errors == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
common/riscv_div_pkg.sv
common/div_iter_if.sv
common/div_fin_if.sv
divider/div_ctrl.sv
divider/div_iter.sv
divider/div_result.sv
hdl/riscv_div_top.sv
bench/riscv_div_checker.sv
bench/tb_riscv_div.sv

// File: Bender.yml
package:
  name: riscv_div

sources:
  - common/riscv_div_pkg.sv
  - common/div_iter_if.sv
  - common/div_fin_if.sv
  - divider/div_ctrl.sv
  - divider/div_iter.sv
  - divider/div_result.sv
  - hdl/riscv_div_top.sv
  - target: test
    files:
      - bench/riscv_div_checker.sv
      - bench/tb_riscv_div.sv
